// ==== rtl/bpu_settings.svh ====
`ifndef BPU_SETTINGS_SVH
`define BPU_SETTINGS_SVH

// instructions fetched per cycle
`define BPU_N 2

// global history width, also the width of every table index
`define BPU_HISTORY_BITS 4

// entries in each of the three prediction tables
`define BPU_PHT_SZ 16

// direct-mapped target buffer sets
`define BPU_BTB_SETS 8

`define BPU_ADDR_BITS 32

// in-flight branch records
`define BPU_BS_DEPTH 8

`endif

// ==== rtl/bpu_pkg.sv ====
`default_nettype none

`include "bpu_settings.svh"

package bpu_pkg;

    // instruction address
    typedef logic [`BPU_ADDR_BITS-1:0] addr_t;

    // global branch history, newest outcome in bit 0
    typedef logic [`BPU_HISTORY_BITS-1:0] bhr_t;

    // saturating counter, upper bit is the prediction
    typedef logic [1:0] two_bit_t;

    // how one branch was predicted, carried until it resolves
    typedef struct packed {
        logic                         gshare_predict_taken;
        logic                         simple_predict_taken;
        logic [`BPU_HISTORY_BITS-1:0] meta_idx;
        logic [`BPU_HISTORY_BITS-1:0] gshare_idx;
        bhr_t                         bhr_state;
    } bp_packet_t;

    // fetch request for one aligned group
    typedef struct packed {
        logic  valid;
        addr_t pc;
    } fetch_group_t;

    // execute's outcome for the oldest branch
    typedef struct packed {
        logic  valid;
        logic  actual_taken;
        addr_t actual_target;
    } resolve_t;

    // one branch stack record
    typedef struct packed {
        addr_t      pc;
        logic       predicted_taken;
        addr_t      predicted_target;
        bp_packet_t packet;
    } bs_entry_t;

    // target buffer write on a taken resolve
    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t target;
    } btb_update_t;

endpackage

`default_nettype wire

// ==== rtl/branch_target_buffer.sv ====
`default_nettype none

`include "bpu_settings.svh"

module branch_target_buffer (
    input  logic                                  clock,
    input  logic                                  reset,
    input  bpu_pkg::addr_t      [`BPU_N-1:0]      pcs,
    input  bpu_pkg::btb_update_t                  btb_update,
    output logic                [`BPU_N-1:0]      btb_hits,
    output bpu_pkg::addr_t      [`BPU_N-1:0]      btb_targets
);

    localparam int IDX_BITS = $clog2(`BPU_BTB_SETS);
    // word offset sits below the index
    localparam int TAG_BITS = `BPU_ADDR_BITS - IDX_BITS - 2;

    logic [`BPU_BTB_SETS-1:0] set_valid;
    logic [TAG_BITS-1:0]      set_tag    [`BPU_BTB_SETS];
    bpu_pkg::addr_t           set_target [`BPU_BTB_SETS];

    logic [IDX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0] wr_tag;

    assign wr_idx = btb_update.pc[IDX_BITS+1:2];
    assign wr_tag = btb_update.pc[`BPU_ADDR_BITS-1:IDX_BITS+2];

    // one lookup port per fetch slot
    always_comb begin
        logic [IDX_BITS-1:0] rd_idx;
        logic [TAG_BITS-1:0] rd_tag;
        rd_idx = '0;
        rd_tag = '0;
        for (int i = 0; i < `BPU_N; i++) begin
            rd_idx = pcs[i][IDX_BITS+1:2];
            rd_tag = pcs[i][`BPU_ADDR_BITS-1:IDX_BITS+2];
            btb_hits[i]    = set_valid[rd_idx] && (set_tag[rd_idx] == rd_tag);
            btb_targets[i] = set_target[rd_idx];
        end
    end

    // valid bits are control state
    always_ff @(posedge clock) begin
        if (reset) begin
            set_valid <= '0;
        end else if (btb_update.valid) begin
            set_valid[wr_idx] <= 1'b1;
        end
    end

    // tag and target payload, written with the valid bit
    always_ff @(posedge clock) begin
        if (btb_update.valid) begin
            set_tag[wr_idx]    <= wr_tag;
            set_target[wr_idx] <= btb_update.target;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/branch_slot_order.sv ====
`default_nettype none

`include "bpu_settings.svh"

module branch_slot_order (
    input  logic [`BPU_N-1:0]              btb_hits,
    input  logic [`BPU_N-1:0]              branches_taken,
    output logic [`BPU_N-1:0][`BPU_N-1:0]  branch_gnt_bus,
    output logic [`BPU_N-1:0]              final_branch_gnt_line,
    output logic                           no_branches_fetched,
    output logic [`BPU_N-1:0]              keep_slots
);

    assign no_branches_fetched = ~|btb_hits;

    // row j marks the slot of the j-th branch in address order
    // depends on hits only, so the predictor can use it before it knows any outcome
    always_comb begin
        int rank;
        rank = 0;
        branch_gnt_bus = '0;
        for (int i = 0; i < `BPU_N; i++) begin
            if (btb_hits[i]) begin
                branch_gnt_bus[rank][i] = 1'b1;
                rank = rank + 1;
            end
        end
    end

    // walk the hits in order until the first taken one
    // the last hit visited ends the group
    always_comb begin
        logic cut;
        cut = 1'b0;
        final_branch_gnt_line = '0;
        keep_slots = '0;
        for (int i = 0; i < `BPU_N; i++) begin
            if (btb_hits[i] && !cut) begin
                final_branch_gnt_line    = '0;
                final_branch_gnt_line[i] = 1'b1;
                keep_slots[i]            = 1'b1;
                cut                      = branches_taken[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tournament_predictor.sv ====
`default_nettype none

`include "bpu_settings.svh"

module tournament_predictor (
    input  logic                                      clock,
    input  logic                                      reset,
    input  bpu_pkg::addr_t      [`BPU_N-1:0]          pcs_out,
    input  logic                                      fetch_valid,
    input  logic                [`BPU_N-1:0][`BPU_N-1:0] branch_gnt_bus,
    input  logic                [`BPU_N-1:0]          final_branch_gnt_line,
    input  logic                                      no_branches_fetched,
    input  logic                [`BPU_N-1:0]          btb_hits,
    output bpu_pkg::bp_packet_t [`BPU_N-1:0]          bp_packets,
    output logic                [`BPU_N-1:0]          branches_taken,
    input  bpu_pkg::bp_packet_t                       bs_bp_packet,
    input  logic                                      resolving_valid_branch,
    input  logic                                      actual_taken,
    input  logic                                      mispred,
    input  logic                                      stack_full
);

    localparam int HB = `BPU_HISTORY_BITS;

    bpu_pkg::two_bit_t gshare_pht [`BPU_PHT_SZ];
    bpu_pkg::two_bit_t simple_pht [`BPU_PHT_SZ];
    bpu_pkg::two_bit_t meta_pht   [`BPU_PHT_SZ];
    bpu_pkg::two_bit_t next_gshare_pht [`BPU_PHT_SZ];
    bpu_pkg::two_bit_t next_simple_pht [`BPU_PHT_SZ];
    bpu_pkg::two_bit_t next_meta_pht   [`BPU_PHT_SZ];

    bpu_pkg::bhr_t                bhr;
    bpu_pkg::bhr_t                next_bhr;
    bpu_pkg::bhr_t   [`BPU_N-1:0] assigned_bhrs;

    // saturating step toward the requested direction
    function automatic bpu_pkg::two_bit_t step_counter(input bpu_pkg::two_bit_t count,
                                                       input logic up);
        step_counter = count;
        if (up && count != 2'd3) begin
            step_counter = count + 2'd1;
        end else if (!up && count != 2'd0) begin
            step_counter = count - 2'd1;
        end
    endfunction

    // the j-th branch of the group sees the history shifted by j,
    // standing in for the outcomes of the older branches in the group
    always_comb begin
        assigned_bhrs = '0;
        for (int i = 0; i < `BPU_N; i++) begin
            for (int j = 0; j < `BPU_N; j++) begin
                if (branch_gnt_bus[j][i]) begin
                    assigned_bhrs[i] = bhr << j;
                end
            end
        end
    end

    // speculative history after this group, from its final branch
    always_comb begin
        next_bhr = bhr;
        if (!no_branches_fetched) begin
            for (int i = 0; i < `BPU_N; i++) begin
                if (final_branch_gnt_line[i]) begin
                    next_bhr = {assigned_bhrs[i][HB-2:0], branches_taken[i]};
                end
            end
        end
    end

    // train on resolve first, so a same-cycle fetch already sees the new counters
    always_comb begin
        logic gshare_right;
        logic simple_right;
        next_gshare_pht = gshare_pht;
        next_simple_pht = simple_pht;
        next_meta_pht   = meta_pht;
        gshare_right = (actual_taken == bs_bp_packet.gshare_predict_taken);
        simple_right = (actual_taken == bs_bp_packet.simple_predict_taken);
        if (resolving_valid_branch) begin
            next_gshare_pht[bs_bp_packet.gshare_idx] =
                step_counter(gshare_pht[bs_bp_packet.gshare_idx], actual_taken);
            next_simple_pht[bs_bp_packet.meta_idx] =
                step_counter(simple_pht[bs_bp_packet.meta_idx], actual_taken);
            // chooser only moves when exactly one table was right
            if (gshare_right != simple_right) begin
                next_meta_pht[bs_bp_packet.meta_idx] =
                    step_counter(meta_pht[bs_bp_packet.meta_idx], gshare_right);
            end
        end
    end

    // per-slot lookup and packet
    always_comb begin
        logic [HB-1:0] pc_idx;
        logic [HB-1:0] gs_idx;
        pc_idx = '0;
        gs_idx = '0;
        bp_packets = '0;
        for (int i = 0; i < `BPU_N; i++) begin
            // bits 5:2 of each slot address
            pc_idx = pcs_out[i][HB+1:2];
            gs_idx = pc_idx ^ assigned_bhrs[i];
            bp_packets[i].gshare_predict_taken = next_gshare_pht[gs_idx][1];
            bp_packets[i].simple_predict_taken = next_simple_pht[pc_idx][1];
            bp_packets[i].meta_idx             = pc_idx;
            bp_packets[i].gshare_idx           = gs_idx;
            bp_packets[i].bhr_state            = assigned_bhrs[i];
            // chooser upper bit set selects gshare
            branches_taken[i] = btb_hits[i] && (next_meta_pht[pc_idx][1] ?
                bp_packets[i].gshare_predict_taken : bp_packets[i].simple_predict_taken);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bhr <= '0;
            for (int i = 0; i < `BPU_PHT_SZ; i++) begin
                gshare_pht[i] <= 2'd2;
                simple_pht[i] <= 2'd1;
                meta_pht[i]   <= 2'd1;
            end
        end else begin
            // repair from the resolving branch beats a speculative update
            if (resolving_valid_branch && mispred) begin
                bhr <= {bs_bp_packet.bhr_state[HB-2:0], actual_taken};
            end else if (fetch_valid && !stack_full) begin
                bhr <= next_bhr;
            end
            gshare_pht <= next_gshare_pht;
            simple_pht <= next_simple_pht;
            meta_pht   <= next_meta_pht;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/branch_stack.sv ====
`default_nettype none

`include "bpu_settings.svh"

module branch_stack (
    input  logic                                  clock,
    input  logic                                  reset,
    input  bpu_pkg::fetch_group_t                 fetch,
    input  logic                [`BPU_N-1:0]      keep_slots,
    input  logic                [`BPU_N-1:0]      branches_taken,
    input  bpu_pkg::addr_t      [`BPU_N-1:0]      btb_targets,
    input  bpu_pkg::bp_packet_t [`BPU_N-1:0]      bp_packets,
    input  bpu_pkg::resolve_t                     resolve,
    output bpu_pkg::bp_packet_t                   bs_bp_packet,
    output logic                                  resolving_valid_branch,
    output logic                                  actual_taken,
    output logic                                  mispred,
    output bpu_pkg::addr_t                        redirect_pc,
    output bpu_pkg::btb_update_t                  btb_update,
    output bpu_pkg::addr_t                        next_pc,
    output logic                                  stack_full
);

    localparam int PTR_BITS  = $clog2(`BPU_BS_DEPTH);
    localparam int CNT_BITS  = $clog2(`BPU_BS_DEPTH + 1);
    localparam int PUSH_BITS = $clog2(`BPU_N + 1);

    bpu_pkg::bs_entry_t entries [`BPU_BS_DEPTH];
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [CNT_BITS-1:0] count;

    bpu_pkg::bs_entry_t                oldest;
    logic                              accept;
    logic                              pop;
    logic [`BPU_N-1:0]                 push_en;
    logic [`BPU_N-1:0][PTR_BITS-1:0]   push_ptr;
    bpu_pkg::bs_entry_t [`BPU_N-1:0]   push_data;
    logic [PUSH_BITS-1:0]              push_count;

    // a whole group must fit
    assign stack_full = count > CNT_BITS'(`BPU_BS_DEPTH - `BPU_N);

    // resolution of the oldest entry
    assign oldest                 = entries[head];
    assign resolving_valid_branch = resolve.valid && (count != '0);
    assign actual_taken           = resolving_valid_branch && resolve.actual_taken;
    assign bs_bp_packet           = oldest.packet;
    assign mispred = resolving_valid_branch &&
        ((oldest.predicted_taken != resolve.actual_taken) ||
         (resolve.actual_taken && oldest.predicted_target != resolve.actual_target));
    assign redirect_pc = !resolving_valid_branch ? '0 :
        resolve.actual_taken ? resolve.actual_target : oldest.pc + 32'd4;

    // every taken resolve refreshes the target buffer
    assign btb_update.valid  = actual_taken;
    assign btb_update.pc     = oldest.pc;
    assign btb_update.target = resolve.actual_target;

    // a mispredict flush drops this cycle's fetch
    assign accept = fetch.valid && !stack_full && !mispred;
    assign pop    = resolving_valid_branch && !mispred;

    // redirect fetch to the first predicted-taken slot
    always_comb begin
        logic found;
        found   = 1'b0;
        next_pc = fetch.pc + 32'd8;
        for (int i = 0; i < `BPU_N; i++) begin
            if (branches_taken[i] && !found) begin
                next_pc = btb_targets[i];
                found   = 1'b1;
            end
        end
    end

    // kept slots get consecutive places from the tail, oldest first
    always_comb begin
        logic [PTR_BITS-1:0] slot_ptr;
        slot_ptr   = tail;
        push_count = '0;
        for (int i = 0; i < `BPU_N; i++) begin
            push_en[i]                    = accept && keep_slots[i];
            push_ptr[i]                   = slot_ptr;
            push_data[i].pc               = fetch.pc + bpu_pkg::addr_t'(4 * i);
            push_data[i].predicted_taken  = branches_taken[i];
            push_data[i].predicted_target = btb_targets[i];
            push_data[i].packet           = bp_packets[i];
            if (push_en[i]) begin
                slot_ptr   = slot_ptr + PTR_BITS'(1);
                push_count = push_count + PUSH_BITS'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `BPU_N; i++) begin
            if (push_en[i]) begin
                entries[push_ptr[i]] <= push_data[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || mispred) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_BITS'(pop);
            tail  <= tail + PTR_BITS'(push_count);
            count <= count + CNT_BITS'(push_count) - CNT_BITS'(pop);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_predict_unit.sv ====
`default_nettype none

`include "bpu_settings.svh"

module fetch_predict_unit (
    input  logic                               clock,
    input  logic                               reset,
    input  bpu_pkg::fetch_group_t              fetch,
    input  bpu_pkg::resolve_t                  resolve,
    output logic               [`BPU_N-1:0]    branches_taken,
    output bpu_pkg::addr_t                     next_pc,
    output logic                               mispred,
    output bpu_pkg::addr_t                     redirect_pc,
    output logic                               stack_full
);

    bpu_pkg::addr_t       [`BPU_N-1:0]             pcs;
    logic                 [`BPU_N-1:0]             btb_hits;
    bpu_pkg::addr_t       [`BPU_N-1:0]             btb_targets;
    logic                 [`BPU_N-1:0][`BPU_N-1:0] branch_gnt_bus;
    logic                 [`BPU_N-1:0]             final_branch_gnt_line;
    logic                                          no_branches_fetched;
    logic                 [`BPU_N-1:0]             keep_slots;
    bpu_pkg::bp_packet_t  [`BPU_N-1:0]             bp_packets;
    bpu_pkg::bp_packet_t                           bs_bp_packet;
    logic                                          resolving_valid_branch;
    logic                                          actual_taken;
    bpu_pkg::btb_update_t                          btb_update;

    // consecutive word addresses of the group
    always_comb begin
        for (int i = 0; i < `BPU_N; i++) begin
            pcs[i] = fetch.pc + bpu_pkg::addr_t'(4 * i);
        end
    end

    branch_target_buffer btb_i (
        .clock, .reset, .pcs, .btb_update, .btb_hits, .btb_targets
    );

    branch_slot_order order_i (
        .btb_hits, .branches_taken, .branch_gnt_bus, .final_branch_gnt_line,
        .no_branches_fetched, .keep_slots
    );

    tournament_predictor predictor_i (
        .clock, .reset, .pcs_out(pcs), .fetch_valid(fetch.valid), .branch_gnt_bus,
        .final_branch_gnt_line, .no_branches_fetched, .btb_hits, .bp_packets,
        .branches_taken, .bs_bp_packet, .resolving_valid_branch, .actual_taken,
        .mispred, .stack_full
    );

    branch_stack stack_i (
        .clock, .reset, .fetch, .keep_slots, .branches_taken, .btb_targets,
        .bp_packets, .resolve, .bs_bp_packet, .resolving_valid_branch,
        .actual_taken, .mispred, .redirect_pc, .btb_update, .next_pc, .stack_full
    );

endmodule

`default_nettype wire

// ==== verification/fetch_predict_unit_assert.sv ====
`default_nettype none

`include "bpu_settings.svh"

module fetch_predict_unit_assert (
    input logic                                 clock,
    input logic                                 reset,
    input logic                                 stack_full,
    input logic [$clog2(`BPU_BS_DEPTH)-1:0]     head,
    input logic [$clog2(`BPU_BS_DEPTH)-1:0]     tail,
    input logic [$clog2(`BPU_BS_DEPTH + 1)-1:0] count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PTR_BITS = $clog2(`BPU_BS_DEPTH);

    // occupancy never passes the depth
    count_in_range: assert property (@(posedge clock) disable iff (reset)
        count <= `BPU_BS_DEPTH)
        else $error("branch stack holds more records than its depth");

    // a full stack takes no new records so occupancy cannot grow
    no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        stack_full |=> (count <= $past(count)))
        else $error("branch stack grew while it was full");

    // read and write pointers stay as far apart as the count says, also across a flush
    pointers_follow_count: assert property (@(posedge clock) disable iff (reset)
        tail == head + PTR_BITS'(count))
        else $error("branch stack pointers disagree with the record count");

endmodule

`default_nettype wire

// ==== verification/fetch_predict_unit_tb.sv ====
`default_nettype none

`include "bpu_settings.svh"

module fetch_predict_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // one cycle of stimulus and the outputs expected before the next edge
    typedef struct packed {
        logic [2:0]        test_id;
        logic              fetch_valid;
        bpu_pkg::addr_t    fetch_pc;
        logic              resolve_valid;
        logic              resolve_taken;
        bpu_pkg::addr_t    resolve_target;
        logic              seed_valid;
        bpu_pkg::addr_t    seed_pc;
        bpu_pkg::addr_t    seed_target;
        logic [`BPU_N-1:0] exp_taken;
        bpu_pkg::addr_t    exp_next_pc;
        logic              exp_mispred;
        bpu_pkg::addr_t    exp_redirect_pc;
        logic              exp_full;
    } row_t;

    logic                  clock;
    logic                  reset;
    bpu_pkg::fetch_group_t fetch;
    bpu_pkg::resolve_t     resolve;
    logic [`BPU_N-1:0]     branches_taken;
    bpu_pkg::addr_t        next_pc;
    logic                  mispred;
    bpu_pkg::addr_t        redirect_pc;
    logic                  stack_full;

    row_t                 rows[$];
    string                test_names [7];
    bpu_pkg::btb_update_t seed_update;
    logic                 seeding;
    int                   row_index;
    int                   check_count;
    int                   error_count;
    int                   test_checks;
    int                   test_errors;
    int                   cycle_count;
    int                   timeout_limit;

    fetch_predict_unit dut_i (
        .clock          (clock),
        .reset          (reset),
        .fetch          (fetch),
        .resolve        (resolve),
        .branches_taken (branches_taken),
        .next_pc        (next_pc),
        .mispred        (mispred),
        .redirect_pc    (redirect_pc),
        .stack_full     (stack_full)
    );

    bind fetch_predict_unit fetch_predict_unit_assert assert_i (
        .clock, .reset, .stack_full,
        .head(stack_i.head), .tail(stack_i.tail), .count(stack_i.count)
    );

    always #20 clock = ~clock;

    // run limit grows with the table
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout reached after %0d cycles, the table did not finish", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic add_row(input int test_id, input logic fetch_valid,
                           input bpu_pkg::addr_t fetch_pc, input logic resolve_valid,
                           input logic resolve_taken, input bpu_pkg::addr_t resolve_target,
                           input logic [`BPU_N-1:0] exp_taken, input bpu_pkg::addr_t exp_next_pc,
                           input logic exp_mispred, input bpu_pkg::addr_t exp_redirect_pc,
                           input logic exp_full);
        row_t r;
        r                 = '0;
        r.test_id         = 3'(test_id);
        r.fetch_valid     = fetch_valid;
        r.fetch_pc        = fetch_pc;
        r.resolve_valid   = resolve_valid;
        r.resolve_taken   = resolve_taken;
        r.resolve_target  = resolve_target;
        r.exp_taken       = exp_taken;
        r.exp_next_pc     = exp_next_pc;
        r.exp_mispred     = exp_mispred;
        r.exp_redirect_pc = exp_redirect_pc;
        r.exp_full        = exp_full;
        rows.push_back(r);
    endtask

    // no fetch and no resolve, pc 0 misses the buffer so next_pc is 8
    task automatic add_idle(input int test_id, input logic exp_full);
        add_row(test_id, 1'b0, '0, 1'b0, 1'b0, '0, '0, 32'h8, 1'b0, '0, exp_full);
    endtask

    // the buffer only learns branches it already holds
    // so an idle cycle with a forced write stands in for a pre-decode fill
    task automatic add_seed(input int test_id, input bpu_pkg::addr_t pc,
                            input bpu_pkg::addr_t target);
        row_t r;
        add_idle(test_id, 1'b0);
        r             = rows.pop_back();
        r.seed_valid  = 1'b1;
        r.seed_pc     = pc;
        r.seed_target = target;
        rows.push_back(r);
    endtask

    task automatic build_table();
        test_names[1] = "cold start";
        test_names[2] = "learned taken branch";
        test_names[3] = "training to not-taken";
        test_names[4] = "group cut";
        test_names[5] = "stack full";
        test_names[6] = "flush on mispredict";
        // every lookup misses
        add_idle(1, 1'b0);
        add_row(1, 1'b1, 32'h40, 1'b0, 1'b0, '0, 2'b00, 32'h48, 1'b0, '0, 1'b0);
        add_row(1, 1'b1, 32'h1000, 1'b0, 1'b0, '0, 2'b00, 32'h1008, 1'b0, '0, 1'b0);
        // bimodal 1 picked by chooser 1, so the first pass is not taken
        add_seed(2, 32'h100, 32'h200);
        add_row(2, 1'b1, 32'h100, 1'b0, 1'b0, '0, 2'b00, 32'h108, 1'b0, '0, 1'b0);
        add_row(2, 1'b0, '0, 1'b1, 1'b1, 32'h200, 2'b00, 32'h8, 1'b1, 32'h200, 1'b0);
        // chooser now 2 and gshare at index 1 is 2
        add_row(2, 1'b1, 32'h100, 1'b0, 1'b0, '0, 2'b01, 32'h200, 1'b0, '0, 1'b0);
        // two not-taken resolves walk bimodal down and the chooser back to 1
        add_row(3, 1'b0, '0, 1'b1, 1'b0, 32'h200, 2'b00, 32'h8, 1'b1, 32'h104, 1'b0);
        add_row(3, 1'b1, 32'h100, 1'b0, 1'b0, '0, 2'b01, 32'h200, 1'b0, '0, 1'b0);
        add_row(3, 1'b0, '0, 1'b1, 1'b0, 32'h200, 2'b00, 32'h8, 1'b1, 32'h104, 1'b0);
        add_row(3, 1'b1, 32'h100, 1'b0, 1'b0, '0, 2'b00, 32'h108, 1'b0, '0, 1'b0);
        add_row(3, 1'b0, '0, 1'b1, 1'b1, 32'h200, 2'b00, 32'h8, 1'b1, 32'h200, 1'b0);
        // slot 1 known too, slot 0 taken cuts the group each time
        add_seed(4, 32'h104, 32'h300);
        add_row(4, 1'b1, 32'h100, 1'b0, 1'b0, '0, 2'b01, 32'h200, 1'b0, '0, 1'b0);
        add_row(4, 1'b1, 32'h100, 1'b0, 1'b0, '0, 2'b01, 32'h200, 1'b0, '0, 1'b0);
        add_row(4, 1'b0, '0, 1'b1, 1'b1, 32'h200, 2'b00, 32'h8, 1'b0, 32'h200, 1'b0);
        // pc 0x100 plus 4, so the second record is slot 0 of the next group
        add_row(4, 1'b0, '0, 1'b1, 1'b0, 32'h200, 2'b00, 32'h8, 1'b1, 32'h104, 1'b0);
        // two-branch group on fresh counters, both not taken
        add_seed(5, 32'h110, 32'h400);
        add_seed(5, 32'h114, 32'h500);
        for (int g = 0; g < 4; g++) begin
            add_row(5, 1'b1, 32'h110, 1'b0, 1'b0, '0, 2'b00, 32'h118, 1'b0, '0, 1'b0);
        end
        // eight records, this fetch is ignored
        add_row(5, 1'b1, 32'h110, 1'b0, 1'b0, '0, 2'b00, 32'h118, 1'b0, '0, 1'b1);
        add_row(5, 1'b0, '0, 1'b1, 1'b0, 32'h400, 2'b00, 32'h8, 1'b0, 32'h114, 1'b1);
        add_row(5, 1'b0, '0, 1'b1, 1'b0, 32'h500, 2'b00, 32'h8, 1'b0, 32'h118, 1'b1);
        // six left, room for one more group
        add_row(5, 1'b1, 32'h110, 1'b0, 1'b0, '0, 2'b00, 32'h118, 1'b0, '0, 1'b0);
        add_idle(5, 1'b1);
        // oldest is slot 0 of the second group, predicted not taken
        add_row(6, 1'b0, '0, 1'b1, 1'b1, 32'h400, 2'b00, 32'h8, 1'b1, 32'h400, 1'b1);
        add_idle(6, 1'b0);
        // nothing left to resolve
        add_row(6, 1'b0, '0, 1'b1, 1'b1, 32'h400, 2'b00, 32'h8, 1'b0, '0, 1'b0);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("Error: %s is 0x%h, expected 0x%h at row %0d",
                     name, actual, expected, row_index);
        end
    endtask

    task automatic apply_row(input row_t r);
        if (seeding) begin
            release dut_i.btb_update;
            seeding = 1'b0;
        end
        fetch.valid           = r.fetch_valid;
        fetch.pc              = r.fetch_pc;
        resolve.valid         = r.resolve_valid;
        resolve.actual_taken  = r.resolve_taken;
        resolve.actual_target = r.resolve_target;
        if (r.seed_valid) begin
            seed_update.valid  = 1'b1;
            seed_update.pc     = r.seed_pc;
            seed_update.target = r.seed_target;
            force dut_i.btb_update = seed_update;
            seeding = 1'b1;
        end
    endtask

    task automatic check_row(input row_t r);
        check_value("branches_taken", 32'(branches_taken), 32'(r.exp_taken));
        check_value("next_pc", next_pc, r.exp_next_pc);
        check_value("mispred", 32'(mispred), 32'(r.exp_mispred));
        check_value("redirect_pc", redirect_pc, r.exp_redirect_pc);
        check_value("stack_full", 32'(stack_full), 32'(r.exp_full));
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        fetch       = '0;
        resolve     = '0;
        seed_update = '0;
        seeding     = 1'b0;
        build_table();
        timeout_limit = rows.size() * 2 + 50;
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;
        for (row_index = 0; row_index < rows.size(); row_index++) begin
            apply_row(rows[row_index]);
            // outputs settle well before the falling edge
            @(negedge clock);
            check_row(rows[row_index]);
            if (row_index + 1 == rows.size() ||
                rows[row_index + 1].test_id != rows[row_index].test_id) begin
                $display("test %0d %s: %0d checks, %0d errors", rows[row_index].test_id,
                         test_names[rows[row_index].test_id], test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
            @(posedge clock);
            #2;
        end
        apply_row('0);
        $display("summary: %0d rows, %0d checks, %0d errors",
                 rows.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bpu.f ====
+incdir+rtl
rtl/bpu_pkg.sv
rtl/branch_target_buffer.sv
rtl/branch_slot_order.sv
rtl/tournament_predictor.sv
rtl/branch_stack.sv
rtl/fetch_predict_unit.sv
verification/fetch_predict_unit_assert.sv
verification/fetch_predict_unit_tb.sv

// ==== run_bpu.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module fetch_predict_unit_tb -f bpu.f -Mdir obj_dir -o sim_bpu

status=0
./obj_dir/sim_bpu > run_bpu.log 2>&1 || status=$?
cat run_bpu.log

if [ "$status" -ne 0 ] || grep -q "TESTBENCH FAILED" run_bpu.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished cleanly"
